//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - logic/params_pkg.sv
      - logic/mem_pkg.sv
      - logic/mem_stage_ctrl.sv
      - logic/mem_latency_timer.sv
      - logic/dmem.sv
      - logic/mem_wb_reg.sv
      - logic/mem_subsystem_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_mem_subsystem.sv

//--- compile.f
logic/params_pkg.sv
logic/mem_pkg.sv
logic/mem_stage_ctrl.sv
logic/mem_latency_timer.sv
logic/dmem.sv
logic/mem_wb_reg.sv
logic/mem_subsystem_top.sv
test/tb_clk_gen.sv
test/tb_mem_subsystem.sv

//--- logic/dmem.sv
`timescale 1ns/100ps

module dmem
  import params_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rd_req_valid_i,
  input  logic                  wr_req_valid_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  access_size_t          size_i,
  input  logic [DATA_WIDTH-1:0] wr_data_i,
  output logic [DATA_WIDTH-1:0] rd_data_o
);

  logic [DATA_WIDTH-1:0]     mem_q [MEM_SIZE];
  logic [$clog2(MEM_SIZE)-1:0] word_idx;
  logic [DATA_WIDTH/8-1:0]   byte_en;
  logic [DATA_WIDTH-1:0]     lane_data;

  // Word index; address bits above the array are ignored.
  assign word_idx = addr_i[$clog2(MEM_SIZE)+1:2];

  // ******************************************************************
  // Byte lanes
  // ******************************************************************

  always_comb begin
    case (size_i)
      ACCESS_BYTE: byte_en = (DATA_WIDTH/8)'(1) << addr_i[1:0];
      ACCESS_HALF: byte_en = addr_i[1] ? 4'b1100 : 4'b0011;
      default:     byte_en = '1;
    endcase
  end

  // Store data is replicated so every enabled lane sees its byte.
  always_comb begin
    for (int i = 0; i < DATA_WIDTH/8; i++) begin
      case (size_i)
        ACCESS_BYTE: lane_data[i*8 +: 8] = wr_data_i[7:0];
        ACCESS_HALF: lane_data[i*8 +: 8] = wr_data_i[(i%2)*8 +: 8];
        default:     lane_data[i*8 +: 8] = wr_data_i[i*8 +: 8];
      endcase
    end
  end

  // ******************************************************************
  // Array
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (wr_req_valid_i) begin
      for (int i = 0; i < DATA_WIDTH/8; i++) begin
        if (byte_en[i]) begin
          mem_q[word_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
        end
      end
    end
  end

  // The read word stays put until the next read.
  always_ff @(posedge clk_i) begin
    if (rd_req_valid_i) begin
      rd_data_o <= mem_q[word_idx];
    end
  end

endmodule : dmem

//--- logic/mem_latency_timer.sv
`timescale 1ns/100ps

module mem_latency_timer
  import mem_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic done_o
);

  logic [LAT_CNT_WIDTH-1:0] cnt_q;
  logic                     busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= LAT_CNT_WIDTH'(MEM_LATENCY - 1);
    end else if (busy_q) begin
      // Count down, then drop busy after the done cycle.
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // High for the single cycle in which the count sits at zero.
  assign done_o = busy_q && (cnt_q == '0);

endmodule : mem_latency_timer

//--- logic/mem_pkg.sv
package mem_pkg;

  // ******************************************************************
  // Access size
  // ******************************************************************

  // Size of a load or store.
  typedef enum logic [1:0] {
    ACCESS_BYTE = 2'b00,
    ACCESS_HALF = 2'b01,
    ACCESS_WORD = 2'b10
  } access_size_t;

  // ******************************************************************
  // Read latency
  // ******************************************************************

  // Cycles from an accepted read request to valid read data.
  localparam int MEM_LATENCY = 3;

  // Wide enough to hold MEM_LATENCY - 1.
  localparam int LAT_CNT_WIDTH = 2;

endpackage : mem_pkg

//--- logic/mem_stage_ctrl.sv
`timescale 1ns/100ps

module mem_stage_ctrl
  import params_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  is_load_i,
  input  logic                  is_store_i,
  input  access_size_t          access_size_i,
  input  logic [DATA_WIDTH-1:0] alu_result_i,
  input  logic [DATA_WIDTH-1:0] reg_a_data_i,
  input  logic                  mem_data_valid_i,
  output logic                  stall_o,
  output logic                  rd_req_valid_o,
  output logic                  wr_req_valid_o,
  output logic                  timer_start_o,
  output logic [ADDR_WIDTH-1:0] mem_req_address_o,
  output access_size_t          req_access_size_o,
  output logic [DATA_WIDTH-1:0] wr_data_o,
  output logic                  wb_valid_d_o,
  output logic                  wb_load_d_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q;
  state_t state_d;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Only READY accepts; IDLE and WAITING hold the upstream.
  assign stall_o = (state_q != READY);

  // The request fields follow the upstream operation.
  assign mem_req_address_o = alu_result_i;
  assign req_access_size_o = access_size_i;
  assign wr_data_o         = reg_a_data_i;

  always_comb begin
    state_d        = state_q;
    rd_req_valid_o = 1'b0;
    wr_req_valid_o = 1'b0;
    timer_start_o  = 1'b0;
    wb_valid_d_o   = 1'b0;
    wb_load_d_o    = 1'b0;

    case (state_q)
      IDLE: begin
        state_d = READY;
      end
      READY: begin
        if (valid_i) begin
          if (is_load_i) begin
            rd_req_valid_o = 1'b1;
            timer_start_o  = 1'b1;
            wb_load_d_o    = 1'b1;
            state_d        = WAITING;
          end else if (is_store_i) begin
            wr_req_valid_o = 1'b1;
            wb_valid_d_o   = 1'b1;
          end else begin
            wb_valid_d_o   = 1'b1;
          end
        end
      end
      WAITING: begin
        // Read data is valid, so the load retires.
        if (mem_data_valid_i) begin
          wb_valid_d_o = 1'b1;
          state_d      = READY;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule : mem_stage_ctrl

//--- logic/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top
  import params_pkg::*;
  import mem_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  logic                      is_load_i,
  input  logic                      is_store_i,
  input  logic                      reg_wr_en_i,
  input  access_size_t              access_size_i,
  input  logic [DATA_WIDTH-1:0]     alu_result_i,
  input  logic [DATA_WIDTH-1:0]     reg_a_data_i,
  input  logic [REGISTER_WIDTH-1:0] wr_reg_i,
  output logic                      stall_o,
  output logic                      wb_valid_o,
  output logic                      wb_reg_wr_en_o,
  output logic [REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [DATA_WIDTH-1:0]     wb_data_o
);

  logic                  rd_req_valid;
  logic                  wr_req_valid;
  logic                  timer_start;
  logic                  mem_data_valid;
  logic [ADDR_WIDTH-1:0] mem_req_address;
  access_size_t          req_access_size;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] mem_rd_data;
  logic                  wb_valid_d;
  logic                  wb_load_d;

  mem_stage_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .valid_i           (valid_i),
    .is_load_i         (is_load_i),
    .is_store_i        (is_store_i),
    .access_size_i     (access_size_i),
    .alu_result_i      (alu_result_i),
    .reg_a_data_i      (reg_a_data_i),
    .mem_data_valid_i  (mem_data_valid),
    .stall_o           (stall_o),
    .rd_req_valid_o    (rd_req_valid),
    .wr_req_valid_o    (wr_req_valid),
    .timer_start_o     (timer_start),
    .mem_req_address_o (mem_req_address),
    .req_access_size_o (req_access_size),
    .wr_data_o         (wr_data),
    .wb_valid_d_o      (wb_valid_d),
    .wb_load_d_o       (wb_load_d)
  );

  mem_latency_timer i_timer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (timer_start),
    .done_o  (mem_data_valid)
  );

  dmem i_dmem (
    .clk_i          (clk_i),
    .rd_req_valid_i (rd_req_valid),
    .wr_req_valid_i (wr_req_valid),
    .addr_i         (mem_req_address),
    .size_i         (req_access_size),
    .wr_data_i      (wr_data),
    .rd_data_o      (mem_rd_data)
  );

  mem_wb_reg i_wb_reg (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_valid_d_i   (wb_valid_d),
    .wb_load_d_i    (wb_load_d),
    .reg_wr_en_i    (reg_wr_en_i),
    .wr_reg_i       (wr_reg_i),
    .alu_result_i   (alu_result_i),
    .access_size_i  (access_size_i),
    .mem_rd_data_i  (mem_rd_data),
    .wb_valid_o     (wb_valid_o),
    .wb_reg_wr_en_o (wb_reg_wr_en_o),
    .wb_wr_reg_o    (wb_wr_reg_o),
    .wb_data_o      (wb_data_o)
  );

endmodule : mem_subsystem_top

//--- logic/mem_wb_reg.sv
`timescale 1ns/100ps

module mem_wb_reg
  import params_pkg::*;
  import mem_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      wb_valid_d_i,
  input  logic                      wb_load_d_i,
  input  logic                      reg_wr_en_i,
  input  logic [REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic [DATA_WIDTH-1:0]     alu_result_i,
  input  access_size_t              access_size_i,
  input  logic [DATA_WIDTH-1:0]     mem_rd_data_i,
  output logic                      wb_valid_o,
  output logic                      wb_reg_wr_en_o,
  output logic [REGISTER_WIDTH-1:0] wb_wr_reg_o,
  output logic [DATA_WIDTH-1:0]     wb_data_o
);

  logic                  ld_pending_q;
  logic [1:0]            ld_offset_q;
  access_size_t          ld_size_q;
  logic [DATA_WIDTH-1:0] ld_shifted;
  logic [DATA_WIDTH-1:0] ld_data;

  // Byte offset and size are latched when the load is issued.
  always_ff @(posedge clk_i) begin
    if (wb_load_d_i) begin
      ld_offset_q <= alu_result_i[1:0];
      ld_size_q   <= access_size_i;
    end
  end

  // Move the addressed lanes down, then zero-extend.
  assign ld_shifted = mem_rd_data_i >> {ld_offset_q, 3'b000};

  always_comb begin
    case (ld_size_q)
      ACCESS_BYTE: ld_data = DATA_WIDTH'(ld_shifted[7:0]);
      ACCESS_HALF: ld_data = DATA_WIDTH'(ld_shifted[15:0]);
      default:     ld_data = mem_rd_data_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ld_pending_q   <= 1'b0;
      wb_valid_o     <= 1'b0;
      wb_reg_wr_en_o <= 1'b0;
    end else begin
      if (wb_load_d_i) begin
        ld_pending_q <= 1'b1;
      end else if (wb_valid_d_i) begin
        ld_pending_q <= 1'b0;
      end
      wb_valid_o     <= wb_valid_d_i;
      wb_reg_wr_en_o <= wb_valid_d_i & reg_wr_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_valid_d_i) begin
      wb_wr_reg_o <= wr_reg_i;
      wb_data_o   <= ld_pending_q ? ld_data : alu_result_i;
    end
  end

endmodule : mem_wb_reg

//--- logic/params_pkg.sv
package params_pkg;

  // ******************************************************************
  // Core sizing
  // ******************************************************************

  // Width of a data word and of the ALU result.
  localparam int DATA_WIDTH = 32;

  // Width of a byte address.
  localparam int ADDR_WIDTH = 32;

  // Width of a destination register index.
  localparam int REGISTER_WIDTH = 5;

  // ******************************************************************
  // Data memory
  // ******************************************************************

  // Depth in words; the word index comes from address bits 9:2.
  localparam int MEM_SIZE = 256;

endpackage : params_pkg

//--- test/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam time HALF_PERIOD = 5ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Active-low reset over four rising edges, released on a falling edge.
  initial begin
    rst_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_o <= 1'b1;
  end

endmodule : tb_clk_gen

//--- test/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem
  import params_pkg::*;
  import mem_pkg::*;
();

  localparam int BYTE_AW        = $clog2(MEM_SIZE) + 2;
  localparam int RESET_TIMEOUT  = 20;
  localparam int ACCEPT_TIMEOUT = 16;
  localparam int RETIRE_TIMEOUT = MEM_LATENCY + 8;
  localparam int RANDOM_OPS     = 200;

  logic                      clk;
  logic                      rst;
  logic                      valid;
  logic                      is_load;
  logic                      is_store;
  logic                      reg_wr_en;
  access_size_t              access_size;
  logic [DATA_WIDTH-1:0]     alu_result;
  logic [DATA_WIDTH-1:0]     reg_a_data;
  logic [REGISTER_WIDTH-1:0] wr_reg;
  logic                      stall;
  logic                      wb_valid;
  logic                      wb_reg_wr_en;
  logic [REGISTER_WIDTH-1:0] wb_wr_reg;
  logic [DATA_WIDTH-1:0]     wb_data;

  // Byte-addressed image of data memory.
  logic [7:0]                mem_model [MEM_SIZE*4];
  logic [DATA_WIDTH-1:0]     exp_data_q [$];
  logic [REGISTER_WIDTH-1:0] exp_reg_q [$];
  logic                      exp_en_q [$];

  int     errors;
  int     accepted;
  int     retired;
  integer seed;

  tb_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsystem_top i_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .valid_i        (valid),
    .is_load_i      (is_load),
    .is_store_i     (is_store),
    .reg_wr_en_i    (reg_wr_en),
    .access_size_i  (access_size),
    .alu_result_i   (alu_result),
    .reg_a_data_i   (reg_a_data),
    .wr_reg_i       (wr_reg),
    .stall_o        (stall),
    .wb_valid_o     (wb_valid),
    .wb_reg_wr_en_o (wb_reg_wr_en),
    .wb_wr_reg_o    (wb_wr_reg),
    .wb_data_o      (wb_data)
  );

  // ******************************************************************
  // Reference model
  // ******************************************************************

  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] model_load(input logic [ADDR_WIDTH-1:0] addr,
                                                       input access_size_t size);
    int a;
    a = addr[BYTE_AW-1:0];
    case (size)
      ACCESS_BYTE: return {24'h0, mem_model[a]};
      ACCESS_HALF: return {16'h0, mem_model[a+1], mem_model[a]};
      default:     return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
    endcase
  endfunction

  function automatic void model_store(input logic [ADDR_WIDTH-1:0] addr,
                                      input access_size_t size,
                                      input logic [DATA_WIDTH-1:0] data);
    int a;
    int n;
    a = addr[BYTE_AW-1:0];
    n = (size == ACCESS_BYTE) ? 1 : (size == ACCESS_HALF) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      mem_model[a+i] = data[i*8 +: 8];
    end
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("errors: %0d, accepted: %0d, retired: %0d", errors, accepted, retired);
    $display("Result: FAILED");
    $finish;
  endtask

  // ******************************************************************
  // Upstream driver
  // ******************************************************************

  task automatic issue_op(input logic load, input logic store, input logic wr_en,
                          input access_size_t size, input logic [ADDR_WIDTH-1:0] result,
                          input logic [DATA_WIDTH-1:0] data,
                          input logic [REGISTER_WIDTH-1:0] rd);
    int cycles;
    valid       = 1'b1;
    is_load     = load;
    is_store    = store;
    reg_wr_en   = wr_en;
    access_size = size;
    alu_result  = result;
    reg_a_data  = data;
    wr_reg      = rd;
    cycles = 0;
    while (stall !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACCEPT_TIMEOUT) begin
        stop_on_timeout("operation was never accepted, stall_o stayed high");
      end
    end
    // Taken at the coming rising edge.
    if (load) begin
      exp_data_q.push_back(model_load(result, size));
    end else begin
      exp_data_q.push_back(result);
    end
    exp_reg_q.push_back(rd);
    exp_en_q.push_back(wr_en);
    if (store) begin
      model_store(result, size, data);
    end
    accepted++;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (wb_valid !== 1'b1) begin
        assert (load) else begin
          errors++;
          $display("operation did not retire on the cycle after it was accepted");
        end
        assert (stall === 1'b1) else begin
          errors++;
          $display("error: stall_o 0x%0h expected 0x1 while a load waits", stall);
        end
        if (cycles > RETIRE_TIMEOUT) begin
          stop_on_timeout("accepted operation never reached write-back");
        end
      end
    end while (wb_valid !== 1'b1);
    valid = 1'b0;
  endtask

  // ******************************************************************
  // Write-back checks
  // ******************************************************************

  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (!rst) begin
        assert (stall === 1'b1 && wb_valid === 1'b0) else begin
          errors++;
          $display("error: stall_o 0x%0h wb_valid_o 0x%0h expected 0x1 0x0 in reset",
                   stall, wb_valid);
        end
      end else if (wb_valid === 1'b1) begin
        // Every write-back counts, so a duplicate shows up in the totals.
        retired++;
        assert (exp_data_q.size() != 0) else begin
          errors++;
          $display("wb_valid_o rose with no accepted operation pending");
        end
        if (exp_data_q.size() != 0) begin
          assert (wb_data === exp_data_q[0]) else begin
            errors++;
            $display("error: wb_data_o 0x%08h expected 0x%08h", wb_data, exp_data_q[0]);
          end
          assert (wb_wr_reg === exp_reg_q[0]) else begin
            errors++;
            $display("error: wb_wr_reg_o 0x%02h expected 0x%02h", wb_wr_reg, exp_reg_q[0]);
          end
          assert (wb_reg_wr_en === exp_en_q[0]) else begin
            errors++;
            $display("error: wb_reg_wr_en_o 0x%0h expected 0x%0h",
                     wb_reg_wr_en, exp_en_q[0]);
          end
          void'(exp_data_q.pop_front());
          void'(exp_reg_q.pop_front());
          void'(exp_en_q.pop_front());
        end
      end else begin
        assert (wb_reg_wr_en === 1'b0) else begin
          errors++;
          $display("error: wb_reg_wr_en_o 0x%0h expected 0x0 without wb_valid_o",
                   wb_reg_wr_en);
        end
      end
    end
  end

  // ******************************************************************
  // Stimulus
  // ******************************************************************

  initial begin
    int                    cycles;
    int                    kind;
    logic [31:0]           rnd;
    logic [31:0]           upper;
    logic [DATA_WIDTH-1:0] data;
    logic [ADDR_WIDTH-1:0] addr;
    access_size_t          size;
    seed        = 32'h83a39e56;
    errors      = 0;
    accepted    = 0;
    retired     = 0;
    valid       = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    reg_wr_en   = 1'b0;
    access_size = ACCESS_WORD;
    alu_result  = '0;
    reg_a_data  = '0;
    wr_reg      = '0;
    cycles = 0;
    while (rst !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        stop_on_timeout("reset was never released");
      end
    end

    // Plain ALU results.
    issue_op(1'b0, 1'b0, 1'b1, ACCESS_WORD, 32'h1234_5678, 32'h0, 5'd3);
    issue_op(1'b0, 1'b0, 1'b0, ACCESS_WORD, 32'hdead_beef, 32'h0, 5'd17);
    issue_op(1'b0, 1'b0, 1'b1, ACCESS_BYTE, 32'h0000_00ff, 32'h0, 5'd31);

    // Word store, then word load of the same address.
    issue_op(1'b0, 1'b1, 1'b0, ACCESS_WORD, 32'h0000_0080, 32'hcafe_f00d, 5'd0);
    issue_op(1'b1, 1'b0, 1'b1, ACCESS_WORD, 32'h0000_0080, 32'h0, 5'd7);

    // Byte merges at each offset.
    for (int off = 0; off < 4; off++) begin
      addr = 32'h100 + off * 4;
      issue_op(1'b0, 1'b1, 1'b0, ACCESS_WORD, addr, fill_word(addr), 5'd0);
      issue_op(1'b0, 1'b1, 1'b0, ACCESS_BYTE, addr + off, 32'h5a5a_5aa0 + off, 5'd0);
      issue_op(1'b1, 1'b0, 1'b1, ACCESS_WORD, addr, 32'h0, 5'd1);
      for (int j = 0; j < 4; j++) begin
        issue_op(1'b1, 1'b0, 1'b1, ACCESS_BYTE, addr + j, 32'h0, 5'(j + 2));
      end
    end

    // Halfword merges at both halves.
    for (int off = 0; off < 4; off += 2) begin
      addr = 32'h140 + off * 4;
      issue_op(1'b0, 1'b1, 1'b0, ACCESS_WORD, addr, fill_word(addr), 5'd0);
      issue_op(1'b0, 1'b1, 1'b0, ACCESS_HALF, addr + off, 32'h7e3c_8001 + off, 5'd0);
      issue_op(1'b1, 1'b0, 1'b1, ACCESS_WORD, addr, 32'h0, 5'd9);
      issue_op(1'b1, 1'b0, 1'b1, ACCESS_HALF, addr, 32'h0, 5'd10);
      issue_op(1'b1, 1'b0, 1'b1, ACCESS_HALF, addr + 2, 32'h0, 5'd11);
    end

    // Random window of 16 words at byte address 0x200, filled first.
    for (int w = 0; w < 16; w++) begin
      addr = 32'h200 + w * 4;
      issue_op(1'b0, 1'b1, 1'b0, ACCESS_WORD, addr, fill_word(addr), 5'd0);
    end
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd   = $random(seed);
      upper = $random(seed);
      data  = $random(seed);
      kind  = rnd[1:0] % 3;
      case (rnd[3:2] % 3)
        0:       size = ACCESS_BYTE;
        1:       size = ACCESS_HALF;
        default: size = ACCESS_WORD;
      endcase
      // Upper address bits are random and must not matter.
      addr = {upper[ADDR_WIDTH-1:BYTE_AW], 8'h80 | 8'(rnd[7:4]), 2'b00};
      if (size == ACCESS_BYTE) begin
        addr[1:0] = rnd[9:8];
      end else if (size == ACCESS_HALF) begin
        addr[1] = rnd[9];
      end
      case (kind)
        0:       issue_op(1'b0, 1'b0, rnd[15], size, upper, data, rnd[14:10]);
        1:       issue_op(1'b0, 1'b1, rnd[15], size, addr, data, rnd[14:10]);
        default: issue_op(1'b1, 1'b0, rnd[15], size, addr, data, rnd[14:10]);
      endcase
    end

    // Let the last write-back be checked.
    repeat (2) @(negedge clk);
    assert (retired == accepted && exp_data_q.size() == 0) else begin
      errors++;
      $display("accepted and retired operation counts differ");
    end

    $display("errors: %0d, accepted: %0d, retired: %0d", errors, accepted, retired);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : tb_mem_subsystem
